// File: ghrd_fabric.f
ghrd_pkg.sv
debounce.sv
reset_pulse_gen.sv
reg_arbiter.sv
pio_regs.sv
ghrd_fabric.sv
ghrd_fabric_asserts.sv
tb_ghrd_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs tb_ghrd_fabric with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f ghrd_fabric.f \
  --top-module tb_ghrd_fabric -o tb_ghrd_fabric
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_ghrd_fabric +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// File: tb_ghrd_fabric.sv
`timescale 1ns/1ps

module tb_ghrd_fabric import ghrd_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 2000;

  logic                   fpga_clk_50;
  logic                   rst_n;
  logic [NUM_DIPSW-1:0]   fpga_dipsw_pio;
  logic [NUM_BUTTONS-1:0] fpga_button_pio;
  logic [NUM_LEDS-1:0]    fpga_led_pio;
  logic [2:0]             hps_reset_req;
  logic                   hps_cold_reset;
  logic                   hps_warm_reset;
  logic                   hps_debug_reset;
  logic                   h2f_wr_stb;
  logic                   h2f_rd_stb;
  logic [REG_ADDR_W-1:0]  h2f_addr;
  logic [REG_DATA_W-1:0]  h2f_wdata;
  logic                   h2f_rd_valid;
  logic [REG_DATA_W-1:0]  h2f_rdata;
  logic                   dbg_wr_stb;
  logic                   dbg_rd_stb;
  logic [REG_ADDR_W-1:0]  dbg_addr;
  logic [REG_DATA_W-1:0]  dbg_wdata;
  logic                   dbg_rd_valid;
  logic [REG_DATA_W-1:0]  dbg_rdata;

  int errors = 0;
  int tests  = 0;
  int failed = 0;
  int cycles = 0;
  int mark;
  logic [REG_DATA_W-1:0] wval;
  logic [REG_DATA_W-1:0] rval;

  ghrd_fabric UUT (.*);

  initial begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;
  end

  // hang guard
  always @(posedge fpga_clk_50) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic int total_errors();
    return errors + UUT.asserts_inst.fail_cnt;
  endfunction

  // move to just after a later rising edge
  task automatic step(input int n);
    repeat (n) @(posedge fpga_clk_50);
    #0.5;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (total_errors() != mark) failed++;
    $display("test %0d %s: %s", tests, name, (total_errors() == mark) ? "pass" : "fail");
    mark = total_errors();
  endtask

  // single read by one master, waits for rd_valid
  task automatic bus_read(input logic use_dbg, input logic [REG_ADDR_W-1:0] addr,
                          output logic [REG_DATA_W-1:0] data);
    int wait_cnt;
    wait_cnt = 0;
    if (use_dbg) begin
      dbg_rd_stb = 1'b1;
      dbg_addr   = addr;
    end else begin
      h2f_rd_stb = 1'b1;
      h2f_addr   = addr;
    end
    step(1);
    dbg_rd_stb = 1'b0;
    h2f_rd_stb = 1'b0;
    while (!(use_dbg ? dbg_rd_valid : h2f_rd_valid) && wait_cnt < 10) begin
      step(1);
      wait_cnt++;
    end
    if (wait_cnt >= 10) begin
      $display("read of address %0d got no response", addr);
      errors++;
    end
    data = use_dbg ? dbg_rdata : h2f_rdata;
  endtask

  // low pulse on button 0 for n cycles, then a quiet gap
  task automatic press_button(input int n);
    fpga_button_pio[0] = 1'b0;
    step(n);
    fpga_button_pio[0] = 1'b1;
    step(4);
  endtask

  initial begin
    void'($urandom(32'he7e7));
    rst_n = 1'b0;
    fpga_dipsw_pio = '0;
    fpga_button_pio = '1;
    hps_reset_req = '0;
    h2f_wr_stb = 1'b0;
    h2f_rd_stb = 1'b0;
    h2f_addr = '0;
    h2f_wdata = '0;
    dbg_wr_stb = 1'b0;
    dbg_rd_stb = 1'b0;
    dbg_addr = '0;
    dbg_wdata = '0;
    mark = 0;
    step(10);
    rst_n = 1'b1;

    check_value("fpga_led_pio", 32'(fpga_led_pio), 32'h0);
    check_value("rd_valid", {30'h0, h2f_rd_valid, dbg_rd_valid}, 32'h0);
    check_value("reset pulses", {29'h0, hps_cold_reset, hps_warm_reset, hps_debug_reset}, 32'h0);
    finish_test("reset state");

    wval = $urandom;
    h2f_wr_stb = 1'b1;
    h2f_addr = ADDR_LED;
    h2f_wdata = wval;
    step(1);
    h2f_wr_stb = 1'b0;
    step(2);
    check_value("fpga_led_pio", 32'(fpga_led_pio), 32'(wval[NUM_LEDS-1:0]));
    bus_read(1'b1, ADDR_LED, rval);
    check_value("dbg_rdata", rval, 32'(wval[NUM_LEDS-1:0]));
    finish_test("led write and read back");

    fpga_dipsw_pio = NUM_DIPSW'($urandom);
    step(2);
    bus_read(1'b0, ADDR_DIPSW, rval);
    check_value("h2f_rdata", rval, 32'(fpga_dipsw_pio));
    bus_read(1'b1, ADDR_HW_EVENT, rval);
    check_value("dbg_rdata", rval, {22'h0, fpga_dipsw_pio, wval[NUM_LEDS-1:0], 2'b00});
    finish_test("switch and event read");

    // both masters in one cycle
    h2f_rd_stb = 1'b1;
    h2f_addr = ADDR_DIPSW;
    dbg_rd_stb = 1'b1;
    dbg_addr = ADDR_LED;
    step(1);
    h2f_rd_stb = 1'b0;
    dbg_rd_stb = 1'b0;
    step(2);
    check_value("h2f_rd_valid", 32'(h2f_rd_valid), 32'h1);
    check_value("h2f_rdata", h2f_rdata, 32'(fpga_dipsw_pio));
    step(1);
    check_value("dbg_rd_valid", 32'(dbg_rd_valid), 32'h1);
    check_value("dbg_rdata", dbg_rdata, 32'(wval[NUM_LEDS-1:0]));
    finish_test("simultaneous reads");

    // bounces shorter than the debounce interval
    for (int i = 0; i < 6; i++) begin
      // first glitch is one sample short of the interval
      if (i == 0) begin
        press_button(DEBOUNCE_CYCLES - 1);
      end else begin
        press_button($urandom_range(DEBOUNCE_CYCLES - 1, 1));
      end
      bus_read(1'b0, ADDR_BUTTON, rval);
      check_value("button glitch", rval, 32'h0);
    end
    fpga_button_pio[0] = 1'b0;
    step(DEBOUNCE_CYCLES + 6);
    bus_read(1'b1, ADDR_BUTTON, rval);
    check_value("button pressed", rval, 32'h1);
    // pressed flag also lands in the event word
    bus_read(1'b0, ADDR_HW_EVENT, rval);
    check_value("h2f_rdata", rval, {22'h0, fpga_dipsw_pio, wval[NUM_LEDS-1:0], 2'b01});
    fpga_button_pio[0] = 1'b1;
    step(DEBOUNCE_CYCLES + 6);
    bus_read(1'b0, ADDR_BUTTON, rval);
    check_value("button released", rval, 32'h0);
    finish_test("button debounce");

    // pulse lengths are checked by the bound assertions
    hps_reset_req[0] = 1'b1;
    step(12);
    hps_reset_req[0] = 1'b0;
    hps_reset_req[1] = 1'b1;
    step(8);
    hps_reset_req[1] = 1'b0;
    hps_reset_req[2] = 1'b1;
    step(6);
    hps_reset_req[2] = 1'b0;
    step(6);
    hps_reset_req[2] = 1'b1;
    // first pulse is over, a restarted one would still run
    step(DEBUG_PULSE_EXT - 8);
    check_value("hps_debug_reset", 32'(hps_debug_reset), 32'h0);
    hps_reset_req[2] = 1'b0;
    finish_test("reset pulses");

    $display("tests %0d, failed %0d, errors %0d", tests, failed, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: ghrd_fabric_asserts.sv
`timescale 1ns/1ps

module ghrd_fabric_asserts import ghrd_pkg::*; (
  input logic                   fpga_clk_50,
  input logic                   rst_n,
  input logic [NUM_LEDS-1:0]    fpga_led_pio,
  input logic [2:0]             hps_reset_req,
  input logic                   hps_cold_reset,
  input logic                   hps_warm_reset,
  input logic                   hps_debug_reset,
  input logic                   h2f_wr_stb,
  input logic                   h2f_rd_stb,
  input logic [REG_ADDR_W-1:0]  h2f_addr,
  input logic [REG_DATA_W-1:0]  h2f_wdata,
  input logic                   h2f_rd_valid,
  input logic                   dbg_rd_stb,
  input logic                   dbg_rd_valid
);

  // failures seen so far, read by the testbench
  int fail_cnt = 0;

  // outputs clear while in reset
  a_reset_state: assert property (@(posedge fpga_clk_50)
    !rst_n |=> fpga_led_pio == '0 && !h2f_rd_valid && !dbg_rd_valid)
    else begin $error("outputs not cleared by reset"); fail_cnt++; end

  // hps is never held off, led shows two edges later
  a_led_write: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    h2f_wr_stb && h2f_addr == ADDR_LED
      |-> ##2 fpga_led_pio == $past(h2f_wdata[NUM_LEDS-1:0], 2))
    else begin $error("led register not updated on time"); fail_cnt++; end

  a_h2f_read: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    h2f_rd_stb |-> ##3 h2f_rd_valid)
    else begin $error("h2f read response late or missing"); fail_cnt++; end

  // debug alone, then debug behind hps
  a_dbg_read: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    dbg_rd_stb && !h2f_rd_stb && !h2f_wr_stb |-> ##3 dbg_rd_valid)
    else begin $error("dbg read response late or missing"); fail_cnt++; end

  a_dbg_read_late: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    dbg_rd_stb && (h2f_rd_stb || h2f_wr_stb) |-> ##4 dbg_rd_valid)
    else begin $error("dbg read behind hps not served next"); fail_cnt++; end

  // exact pulse lengths, edges during a pulse are ignored
  a_cold_pulse: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    $rose(hps_reset_req[0]) && !hps_cold_reset
      |-> ##2 hps_cold_reset [*COLD_PULSE_EXT] ##1 !hps_cold_reset)
    else begin $error("cold reset pulse length wrong"); fail_cnt++; end

  a_warm_pulse: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    $rose(hps_reset_req[1]) && !hps_warm_reset
      |-> ##2 hps_warm_reset [*WARM_PULSE_EXT] ##1 !hps_warm_reset)
    else begin $error("warm reset pulse length wrong"); fail_cnt++; end

  a_debug_pulse: assert property (@(posedge fpga_clk_50) disable iff (!rst_n)
    $rose(hps_reset_req[2]) && !hps_debug_reset
      |-> ##2 hps_debug_reset [*DEBUG_PULSE_EXT] ##1 !hps_debug_reset)
    else begin $error("debug reset pulse length wrong"); fail_cnt++; end

endmodule

bind ghrd_fabric ghrd_fabric_asserts asserts_inst (.*);

// File: ghrd_fabric.sv
`timescale 1ns/1ps

module ghrd_fabric import ghrd_pkg::*; (
  // clock and reset
  input  logic                   fpga_clk_50,
  input  logic                   rst_n,
  // board peripherals
  input  logic [NUM_DIPSW-1:0]   fpga_dipsw_pio,
  input  logic [NUM_BUTTONS-1:0] fpga_button_pio,
  output logic [NUM_LEDS-1:0]    fpga_led_pio,
  // reset requests, cold warm debug
  input  logic [2:0]             hps_reset_req,
  output logic                   hps_cold_reset,
  output logic                   hps_warm_reset,
  output logic                   hps_debug_reset,
  // hps lightweight bridge
  input  logic                   h2f_wr_stb,
  input  logic                   h2f_rd_stb,
  input  logic [REG_ADDR_W-1:0]  h2f_addr,
  input  logic [REG_DATA_W-1:0]  h2f_wdata,
  output logic                   h2f_rd_valid,
  output logic [REG_DATA_W-1:0]  h2f_rdata,
  // debug probe
  input  logic                   dbg_wr_stb,
  input  logic                   dbg_rd_stb,
  input  logic [REG_ADDR_W-1:0]  dbg_addr,
  input  logic [REG_DATA_W-1:0]  dbg_wdata,
  output logic                   dbg_rd_valid,
  output logic [REG_DATA_W-1:0]  dbg_rdata
);

  // debounced, active high
  logic [NUM_BUTTONS-1:0] buttons_pressed;
  // shared register bus
  logic                   reg_wr;
  logic                   reg_rd;
  logic [REG_ADDR_W-1:0]  reg_addr;
  logic [REG_DATA_W-1:0]  reg_wdata;
  logic [REG_DATA_W-1:0]  reg_rdata;

  debounce #(
    .WIDTH (NUM_BUTTONS)
  ) debounce_inst (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .data_in     (fpga_button_pio),
    .data_out    (buttons_pressed)
  );

  // one generator per request bit
  reset_pulse_gen #(
    .PULSE_EXT (COLD_PULSE_EXT)
  ) pulse_cold_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .signal_in   (hps_reset_req[0]),
    .pulse_out   (hps_cold_reset)
  );

  reset_pulse_gen #(
    .PULSE_EXT (WARM_PULSE_EXT)
  ) pulse_warm_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .signal_in   (hps_reset_req[1]),
    .pulse_out   (hps_warm_reset)
  );

  reset_pulse_gen #(
    .PULSE_EXT (DEBUG_PULSE_EXT)
  ) pulse_debug_reset (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .signal_in   (hps_reset_req[2]),
    .pulse_out   (hps_debug_reset)
  );

  // two masters onto one register bus
  reg_arbiter arbiter_inst (
    .fpga_clk_50  (fpga_clk_50),
    .rst_n        (rst_n),
    .h2f_wr_stb   (h2f_wr_stb),
    .h2f_rd_stb   (h2f_rd_stb),
    .h2f_addr     (h2f_addr),
    .h2f_wdata    (h2f_wdata),
    .h2f_rd_valid (h2f_rd_valid),
    .h2f_rdata    (h2f_rdata),
    .dbg_wr_stb   (dbg_wr_stb),
    .dbg_rd_stb   (dbg_rd_stb),
    .dbg_addr     (dbg_addr),
    .dbg_wdata    (dbg_wdata),
    .dbg_rd_valid (dbg_rd_valid),
    .dbg_rdata    (dbg_rdata),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata)
  );

  pio_regs regs_inst (
    .fpga_clk_50     (fpga_clk_50),
    .rst_n           (rst_n),
    .reg_wr          (reg_wr),
    .reg_rd          (reg_rd),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .reg_rdata       (reg_rdata),
    .fpga_dipsw_pio  (fpga_dipsw_pio),
    .buttons_pressed (buttons_pressed),
    .fpga_led_pio    (fpga_led_pio)
  );

endmodule

// File: pio_regs.sv
`timescale 1ns/1ps

module pio_regs import ghrd_pkg::*; (
  input  logic                   fpga_clk_50,
  input  logic                   rst_n,
  // register bus from the arbiter
  input  logic                   reg_wr,
  input  logic                   reg_rd,
  input  logic [REG_ADDR_W-1:0]  reg_addr,
  input  logic [REG_DATA_W-1:0]  reg_wdata,
  output logic [REG_DATA_W-1:0]  reg_rdata,
  // board side
  input  logic [NUM_DIPSW-1:0]   fpga_dipsw_pio,
  input  logic [NUM_BUTTONS-1:0] buttons_pressed,
  output logic [NUM_LEDS-1:0]    fpga_led_pio
);

  // the only writable register
  logic [NUM_LEDS-1:0]   led_reg;
  // switches, leds and buttons in one word
  logic [HW_EVENT_W-1:0] hw_event;
  // selected read value, before the output flop
  logic [REG_DATA_W-1:0] rd_mux;

  assign fpga_led_pio = led_reg;

  // top bits stay zero
  assign hw_event = {
    {(HW_EVENT_W - NUM_DIPSW - NUM_LEDS - NUM_BUTTONS){1'b0}},
    fpga_dipsw_pio,
    led_reg,
    buttons_pressed
  };

  // led register
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      led_reg <= '0;
    end else if (reg_wr && reg_addr == ADDR_LED) begin
      // low bits only
      led_reg <= reg_wdata[NUM_LEDS-1:0];
    end
  end

  // read decode, all values zero extended
  always_comb begin
    case (reg_addr)
      ADDR_LED: begin
        rd_mux = REG_DATA_W'(led_reg);
      end
      ADDR_DIPSW: begin
        rd_mux = REG_DATA_W'(fpga_dipsw_pio);
      end
      ADDR_BUTTON: begin
        rd_mux = REG_DATA_W'(buttons_pressed);
      end
      ADDR_HW_EVENT: begin
        rd_mux = REG_DATA_W'(hw_event);
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  // data one cycle after the read
  always_ff @(posedge fpga_clk_50) begin
    if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

// File: reg_arbiter.sv
`timescale 1ns/1ps

module reg_arbiter import ghrd_pkg::*; (
  input  logic                  fpga_clk_50,
  input  logic                  rst_n,
  // hps lightweight bridge
  input  logic                  h2f_wr_stb,
  input  logic                  h2f_rd_stb,
  input  logic [REG_ADDR_W-1:0] h2f_addr,
  input  logic [REG_DATA_W-1:0] h2f_wdata,
  output logic                  h2f_rd_valid,
  output logic [REG_DATA_W-1:0] h2f_rdata,
  // debug probe
  input  logic                  dbg_wr_stb,
  input  logic                  dbg_rd_stb,
  input  logic [REG_ADDR_W-1:0] dbg_addr,
  input  logic [REG_DATA_W-1:0] dbg_wdata,
  output logic                  dbg_rd_valid,
  output logic [REG_DATA_W-1:0] dbg_rdata,
  // register bus to pio_regs
  output logic                  reg_wr,
  output logic                  reg_rd,
  output logic [REG_ADDR_W-1:0] reg_addr,
  output logic [REG_DATA_W-1:0] reg_wdata,
  input  logic [REG_DATA_W-1:0] reg_rdata
);

  // strobes gathered by master id
  logic [NUM_MST-1:0]                 stb_wr;
  logic [NUM_MST-1:0]                 stb_rd;
  logic [NUM_MST-1:0][REG_ADDR_W-1:0] stb_addr;
  logic [NUM_MST-1:0][REG_DATA_W-1:0] stb_wdata;
  // one waiting access per master
  logic [NUM_MST-1:0]                 pend_vld;
  logic [NUM_MST-1:0]                 pend_wr;
  logic [NUM_MST-1:0][REG_ADDR_W-1:0] pend_addr;
  logic [NUM_MST-1:0][REG_DATA_W-1:0] pend_wdata;
  // pending slot first, else the new strobe
  logic [NUM_MST-1:0]                 req_vld;
  logic [NUM_MST-1:0]                 req_wr;
  logic [NUM_MST-1:0][REG_ADDR_W-1:0] req_addr;
  logic [NUM_MST-1:0][REG_DATA_W-1:0] req_wdata;
  logic gnt_vld;
  logic gnt_id;
  // read tag on the bus, then at the data return
  logic rd_id;
  logic resp_vld;
  logic resp_id;

  always_comb begin
    stb_wr[MST_HPS]    = h2f_wr_stb;
    stb_rd[MST_HPS]    = h2f_rd_stb;
    stb_addr[MST_HPS]  = h2f_addr;
    stb_wdata[MST_HPS] = h2f_wdata;
    stb_wr[MST_DBG]    = dbg_wr_stb;
    stb_rd[MST_DBG]    = dbg_rd_stb;
    stb_addr[MST_DBG]  = dbg_addr;
    stb_wdata[MST_DBG] = dbg_wdata;
    for (int m = 0; m < NUM_MST; m++) begin
      req_vld[m]   = pend_vld[m] | stb_wr[m] | stb_rd[m];
      req_wr[m]    = pend_vld[m] ? pend_wr[m] : stb_wr[m];
      req_addr[m]  = pend_vld[m] ? pend_addr[m] : stb_addr[m];
      req_wdata[m] = pend_vld[m] ? pend_wdata[m] : stb_wdata[m];
    end
  end

  // fixed priority, hps wins
  assign gnt_vld = |req_vld;
  assign gnt_id  = req_vld[MST_HPS] ? MST_HPS : MST_DBG;

  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      pend_vld <= '0;
    end else begin
      for (int m = 0; m < NUM_MST; m++) begin
        pend_vld[m] <= req_vld[m] && !(gnt_vld && gnt_id == 1'(m));
      end
    end
  end

  // slot contents only change while empty
  always_ff @(posedge fpga_clk_50) begin
    for (int m = 0; m < NUM_MST; m++) begin
      if (!pend_vld[m]) begin
        pend_wr[m]    <= stb_wr[m];
        pend_addr[m]  <= stb_addr[m];
        pend_wdata[m] <= stb_wdata[m];
      end
    end
  end

  // one access per cycle onto the register bus
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      reg_wr <= 1'b0;
      reg_rd <= 1'b0;
    end else begin
      reg_wr <= gnt_vld & req_wr[gnt_id];
      reg_rd <= gnt_vld & ~req_wr[gnt_id];
    end
  end

  always_ff @(posedge fpga_clk_50) begin
    reg_addr  <= req_addr[gnt_id];
    reg_wdata <= req_wdata[gnt_id];
    rd_id     <= gnt_id;
  end

  // pio_regs returns data one cycle after reg_rd
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      resp_vld     <= 1'b0;
      h2f_rd_valid <= 1'b0;
      dbg_rd_valid <= 1'b0;
    end else begin
      resp_vld     <= reg_rd;
      h2f_rd_valid <= resp_vld && resp_id == MST_HPS;
      dbg_rd_valid <= resp_vld && resp_id == MST_DBG;
    end
  end

  always_ff @(posedge fpga_clk_50) begin
    resp_id <= rd_id;
    // steer data to the owner of the read
    if (resp_vld && resp_id == MST_HPS) begin
      h2f_rdata <= reg_rdata;
    end
    if (resp_vld && resp_id == MST_DBG) begin
      dbg_rdata <= reg_rdata;
    end
  end

endmodule

// File: reset_pulse_gen.sv
`timescale 1ns/1ps

module reset_pulse_gen import ghrd_pkg::*; #(
  parameter int PULSE_EXT = COLD_PULSE_EXT
) (
  input  logic fpga_clk_50,
  input  logic rst_n,
  // request level
  input  logic signal_in,
  // stretched pulse
  output logic pulse_out
);

  // request sampled, and its previous value
  logic sig_q;
  logic sig_d;
  logic rise;
  logic busy;
  // cycles of pulse left
  logic [PULSE_CNT_W-1:0] ext_cnt;

  assign rise      = sig_q & ~sig_d;
  assign busy      = (ext_cnt != '0);
  assign pulse_out = busy;

  always_ff @(posedge fpga_clk_50) begin
    // a running pulse always finishes, even under rst_n
    if (!rst_n && !busy) begin
      sig_q   <= 1'b0;
      sig_d   <= 1'b0;
      ext_cnt <= '0;
    end else begin
      sig_q <= signal_in;
      sig_d <= sig_q;
      if (busy) begin
        // edges seen here are dropped
        ext_cnt <= ext_cnt - 1'b1;
      end else if (rise) begin
        ext_cnt <= PULSE_CNT_W'(PULSE_EXT);
      end
    end
  end

endmodule

// File: debounce.sv
`timescale 1ns/1ps

module debounce import ghrd_pkg::*; #(
  parameter int WIDTH = NUM_BUTTONS
) (
  input  logic             fpga_clk_50,
  input  logic             rst_n,
  // raw buttons, low when pressed
  input  logic [WIDTH-1:0] data_in,
  // clean pressed flags
  output logic [WIDTH-1:0] data_out
);

  // two-flop synchronizer
  logic [WIDTH-1:0] sync_q1;
  logic [WIDTH-1:0] sync_q2;
  // per-bit count of samples that disagree with data_out
  logic [WIDTH-1:0][DEBOUNCE_CNT_W-1:0] stable_cnt;
  // synchronized level differs from the current flag
  logic [WIDTH-1:0] differs;

  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      // released buttons idle high
      sync_q1 <= '1;
      sync_q2 <= '1;
    end else begin
      sync_q1 <= data_in;
      sync_q2 <= sync_q1;
    end
  end

  // flag is active high for a low input
  assign differs = ~sync_q2 ^ data_out;

  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      stable_cnt <= '0;
      data_out   <= '0;
    end else begin
      for (int i = 0; i < WIDTH; i++) begin
        if (!differs[i]) begin
          // bounce back, start over
          stable_cnt[i] <= '0;
        end else if (stable_cnt[i] == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
          // held long enough
          stable_cnt[i] <= '0;
          data_out[i]   <= ~data_out[i];
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

// File: ghrd_pkg.sv
package ghrd_pkg;

  // register bus
  localparam int REG_ADDR_W = 2;
  localparam int REG_DATA_W = 32;

  // register map
  localparam logic [REG_ADDR_W-1:0] ADDR_LED      = 2'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_DIPSW    = 2'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_BUTTON   = 2'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_HW_EVENT = 2'd3;

  // board peripherals
  localparam int NUM_LEDS    = 4;
  localparam int NUM_DIPSW   = 4;
  localparam int NUM_BUTTONS = 2;
  // packed event word, zero padded at the top
  localparam int HW_EVENT_W  = 28;

  // debounce, simulation scale
  localparam int DEBOUNCE_CYCLES = 8;
  localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES);

  // reset pulse lengths in cycles
  localparam int COLD_PULSE_EXT  = 6;
  localparam int WARM_PULSE_EXT  = 2;
  localparam int DEBUG_PULSE_EXT = 32;
  // sized for the longest pulse
  localparam int PULSE_CNT_W     = $clog2(DEBUG_PULSE_EXT + 1);

  // bus masters
  localparam int   NUM_MST = 2;
  localparam logic MST_HPS = 1'b0;
  localparam logic MST_DBG = 1'b1;

endpackage
